// ==== verilog.f ====
source/dist_cfg_pkg.sv
source/index_rec_pkg.sv
source/index_cal.sv
source/index_fifo.sv
source/dist_index_top.sv
test/index_checker.sv
test/tb_dist_index.sv

// ==== test/tb_dist_index.sv ====
// random requests with a fixed seed; reads held off once long enough to fill the FIFO and stall requests
`timescale 1ns/1ns

module tb_dist_index;

	import dist_cfg_pkg::*;
	import index_rec_pkg::*;

	localparam int N_REQ          = 400;
	localparam int TIMEOUT_CYCLES = N_REQ * 40;
	// read hold window, in cycles
	localparam int HOLD_START     = 600;
	localparam int HOLD_END       = 2600;

	logic   i_clk;
	logic   i_rst_n;
	logic   i_req_valid;
	logic   o_req_ready;
	meas_t  i_rise_data;
	meas_t  i_pulse_data;
	angle_t i_angle1;
	angle_t i_angle2;
	meas_t  i_pulse_start;
	meas_t  i_pulse_divid;
	logic   o_rec_valid;
	rec_t   o_rec_data;
	logic   i_rec_ready;

	int cyc;
	int n_acc;
	int n_rd;
	int tb_errs;
	int chk_errs;
	int chk_pending;

	// three grid setups, divide point not always on the fine grid
	meas_t cfg_start [3] = '{32'd2000, 32'd1500, 32'd300};
	meas_t cfg_divid [3] = '{32'd8000, 32'd13845, 32'd5000};

	dist_index_top i_dut (.*);

	index_checker u_checker (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_req_valid(i_req_valid), .i_req_ready(o_req_ready),
		.i_rise_data(i_rise_data), .i_pulse_data(i_pulse_data),
		.i_angle1(i_angle1), .i_angle2(i_angle2),
		.i_pulse_start(i_pulse_start), .i_pulse_divid(i_pulse_divid),
		.i_rec_valid(o_rec_valid), .i_rec_data(o_rec_data), .i_rec_ready(i_rec_ready),
		.o_err_cnt(chk_errs), .o_pending(chk_pending)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	// ------------------------------------------------------------
	// cycle count, handshake counts, timeout
	// ------------------------------------------------------------

	task automatic report_counts();
		$display("closing report: %0d checker errors, %0d testbench errors", chk_errs, tb_errs);
	endtask

	always @(posedge i_clk) begin
		cyc <= cyc + 1;
		if (i_rst_n && i_req_valid && o_req_ready) n_acc <= n_acc + 1;
		if (i_rst_n && o_rec_valid && i_rec_ready) n_rd <= n_rd + 1;
		if (cyc == TIMEOUT_CYCLES) begin
			tb_errs = tb_errs + 1;
			$display("timeout: only %0d of %0d records read after %0d cycles", n_rd, N_REQ, cyc);
			report_counts();
			$display("Test failures found");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// stimulus helpers
	// ------------------------------------------------------------

	// wide spread around start and divide point, exact edges included
	function automatic meas_t pick_pulse(input meas_t start, input meas_t divid);
		case ($urandom_range(7, 0))
			0: return start;
			1: return divid;
			2: return start - $urandom_range(200, 1);
			3, 4: return start + 1 + $urandom_range(divid - start - 2, 0);
			5, 6: return divid + $urandom_range(20000, 1);
			default: return divid - 1;
		endcase
	endfunction

	// roughly one in ten at or past the limit
	function automatic meas_t pick_rise();
		if ($urandom_range(9, 0) == 0) begin
			return RISE_LIMIT + $urandom_range(3, 0) * 1000;
		end
		return $urandom_range(RISE_LIMIT - 1, 0);
	endfunction

	// called on a falling edge, returns on the one after the transfer
	task automatic send_request(input meas_t rise, input meas_t pulse);
		i_req_valid  = 1'b1;
		i_rise_data  = rise;
		i_pulse_data = pulse;
		i_angle1     = angle_t'($urandom);
		i_angle2     = angle_t'($urandom);
		while (!o_req_ready) @(negedge i_clk);
		@(negedge i_clk);
		i_req_valid = 1'b0;
	endtask

	// only once the calculator is idle again
	task automatic set_config(input int sel);
		while (!o_req_ready) @(negedge i_clk);
		i_pulse_start = cfg_start[sel];
		i_pulse_divid = cfg_divid[sel];
	endtask

	// ------------------------------------------------------------
	// read side, random with one long hold
	// ------------------------------------------------------------

	initial begin
		i_rec_ready = 1'b0;
		forever begin
			@(negedge i_clk);
			if (cyc == HOLD_END) begin
				// 128 in the FIFO plus one stalled in the calculator
				if (n_acc - n_rd != FIFO_DEPTH + 1) begin
					tb_errs = tb_errs + 1;
					$display("error: FIFO did not fill during the read hold, %0d records in flight",
						n_acc - n_rd);
				end
				if (o_req_ready !== 1'b0) begin
					tb_errs = tb_errs + 1;
					$display("mismatch at %0t: o_req_ready expected 0 got %b", $time, o_req_ready);
				end
			end
			if (cyc >= HOLD_START && cyc < HOLD_END) i_rec_ready = 1'b0;
			else i_rec_ready = ($urandom_range(1, 0) == 1);
		end
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------

	initial begin
		int sel;
		void'($urandom(32'ha619_27af));
		cyc = 0;
		n_acc = 0;
		n_rd = 0;
		tb_errs = 0;
		sel = 0;
		i_rst_n = 1'b0;
		i_req_valid = 1'b0;
		i_rise_data = '0;
		i_pulse_data = '0;
		i_angle1 = '0;
		i_angle2 = '0;
		i_pulse_start = cfg_start[0];
		i_pulse_divid = cfg_divid[0];
		repeat (2) @(posedge i_clk);
		@(negedge i_clk);
		i_rst_n = 1'b1;
		@(negedge i_clk);
		if (o_rec_valid !== 1'b0) begin
			tb_errs = tb_errs + 1;
			$display("mismatch at %0t: o_rec_valid expected 0 got %b", $time, o_rec_valid);
		end
		if (o_req_ready !== 1'b1) begin
			tb_errs = tb_errs + 1;
			$display("mismatch at %0t: o_req_ready expected 1 got %b", $time, o_req_ready);
		end
		for (int i = 0; i < N_REQ; i++) begin
			// two config switches, well after the FIFO has filled
			if (i == 220 || i == 320) begin
				sel = sel + 1;
				set_config(sel);
			end
			send_request(pick_rise(), pick_pulse(i_pulse_start, i_pulse_divid));
			repeat ($urandom_range(3, 0)) @(negedge i_clk);
		end
		while (n_rd < N_REQ) @(negedge i_clk);
		repeat (2) @(negedge i_clk);
		if (chk_pending != 0) begin
			tb_errs = tb_errs + 1;
			$display("error: %0d expected records never left the FIFO", chk_pending);
		end
		report_counts();
		if (tb_errs + chk_errs == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== test/index_checker.sv ====
// watches the DUT ports only; config is taken at the accepting edge and must hold until the record is built
`timescale 1ns/1ns

module index_checker (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_req_valid,
	input  logic                  i_req_ready,
	input  dist_cfg_pkg::meas_t   i_rise_data,
	input  dist_cfg_pkg::meas_t   i_pulse_data,
	input  dist_cfg_pkg::angle_t  i_angle1,
	input  dist_cfg_pkg::angle_t  i_angle2,
	input  dist_cfg_pkg::meas_t   i_pulse_start,
	input  dist_cfg_pkg::meas_t   i_pulse_divid,
	input  logic                  i_rec_valid,
	input  index_rec_pkg::rec_t   i_rec_data,
	input  logic                  i_rec_ready,
	output int                    o_err_cnt,
	output int                    o_pending
);

	import dist_cfg_pkg::*;
	import index_rec_pkg::*;

	// records still owed by the DUT, oldest first
	rec_t exp_q[$];

	// ------------------------------------------------------------
	// reference model, plain arithmetic on the grid rules
	// ------------------------------------------------------------

	function automatic rec_t expected_record(input meas_t rise, input meas_t pulse,
		input angle_t a1, input angle_t a2, input meas_t start, input meas_t divid);
		logic [31:0] fine;
		logic [31:0] crs;
		logic [31:0] base;
		logic        out_of_range;
		logic        coarse;
		out_of_range = (rise >= 32'd98304) || (pulse <= start);
		// out of range: done + invalid, everything but the angles cleared
		if (out_of_range) begin
			return {4'b1001, 16'd0, 10'd0, 16'd0, 10'd0, a1, a2};
		end
		coarse = (pulse >= divid);
		if (coarse) begin
			fine = (divid - start) / 128;
			crs  = (pulse - divid) / 512;
		end else begin
			fine = (pulse - start) / 128;
			crs  = 0;
		end
		base = start + fine * 128 + crs * 512;
		return {1'b1, 1'b0, coarse, 1'b0,
			idx_t'(rise / 256), rem_t'(rise % 256),
			idx_t'(fine + crs), rem_t'(pulse - base),
			a1, a2};
	endfunction

	// ------------------------------------------------------------
	// request capture and record compare
	// ------------------------------------------------------------

	initial begin
		o_err_cnt = 0;
		o_pending = 0;
	end

	always @(posedge i_clk) begin
		rec_t exp;
		if (i_rst_n) begin
			// a record leaving the FIFO
			if (i_rec_valid && i_rec_ready) begin
				if (exp_q.size() == 0) begin
					o_err_cnt = o_err_cnt + 1;
					$display("error at %0t: record left the FIFO with no request pending", $time);
				end else begin
					exp = exp_q.pop_front();
					if (i_rec_data !== exp) begin
						o_err_cnt = o_err_cnt + 1;
						$display("mismatch at %0t: o_rec_data expected %h got %h",
							$time, exp, i_rec_data);
					end
				end
			end
			// new request, config as seen on this edge
			if (i_req_valid && i_req_ready) begin
				exp_q.push_back(expected_record(i_rise_data, i_pulse_data, i_angle1,
					i_angle2, i_pulse_start, i_pulse_divid));
			end
			o_pending = exp_q.size();
		end
	end

endmodule

// ==== source/dist_index_top.sv ====
// requests in order, records out in the same order; config ports may change only while idle
`timescale 1ns/1ns

module dist_index_top (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_req_valid,
	output logic                  o_req_ready,
	input  dist_cfg_pkg::meas_t   i_rise_data,
	input  dist_cfg_pkg::meas_t   i_pulse_data,
	input  dist_cfg_pkg::angle_t  i_angle1,
	input  dist_cfg_pkg::angle_t  i_angle2,
	input  dist_cfg_pkg::meas_t   i_pulse_start,
	input  dist_cfg_pkg::meas_t   i_pulse_divid,
	output logic                  o_rec_valid,
	output index_rec_pkg::rec_t   o_rec_data,
	input  logic                  i_rec_ready
);

	import index_rec_pkg::*;

	// calculator to FIFO write side
	logic w_wr_valid;
	logic w_wr_ready;
	rec_t w_wr_data;

	// ------------------------------------------------------------
	// index calculator
	// ------------------------------------------------------------

	index_cal u_index_cal (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_req_valid   (i_req_valid),
		.o_req_ready   (o_req_ready),
		.i_rise_data   (i_rise_data),
		.i_pulse_data  (i_pulse_data),
		.i_angle1      (i_angle1),
		.i_angle2      (i_angle2),
		.i_pulse_start (i_pulse_start),
		.i_pulse_divid (i_pulse_divid),
		.o_wr_valid    (w_wr_valid),
		.o_wr_data     (w_wr_data),
		.i_wr_ready    (w_wr_ready)
	);

	// ------------------------------------------------------------
	// record queue toward the fetch engine
	// ------------------------------------------------------------

	index_fifo u_index_fifo (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_wr_valid (w_wr_valid),
		.i_wr_data  (w_wr_data),
		.o_wr_ready (w_wr_ready),
		.o_rd_valid (o_rec_valid),
		.o_rd_data  (o_rec_data),
		.i_rd_ready (i_rec_ready)
	);

endmodule

// ==== source/index_fifo.sv ====
// single clock record queue whose FIFO_DEPTH must be a power of two
`timescale 1ns/1ns

module index_fifo (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  logic                 i_wr_valid,
	input  index_rec_pkg::rec_t  i_wr_data,
	output logic                 o_wr_ready,
	output logic                 o_rd_valid,
	output index_rec_pkg::rec_t  o_rd_data,
	input  logic                 i_rd_ready
);

	import dist_cfg_pkg::*;
	import index_rec_pkg::*;

	// pointers wrap naturally at the depth
	typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;

	rec_t      mem [FIFO_DEPTH];
	ptr_t      r_wr_ptr;
	ptr_t      r_rd_ptr;
	fifo_cnt_t r_count;

	logic w_full;
	logic w_empty;
	logic w_wr_fire;
	logic w_rd_fire;

	// ------------------------------------------------------------
	// status and handshakes
	// ------------------------------------------------------------

	assign w_full  = (r_count == fifo_cnt_t'(FIFO_DEPTH));
	assign w_empty = (r_count == '0);

	assign w_wr_fire = i_wr_valid && !w_full;
	assign w_rd_fire = i_rd_ready && !w_empty;

	assign o_wr_ready = !w_full;
	assign o_rd_valid = !w_empty;

	// oldest entry shows the cycle after its write
	assign o_rd_data = mem[r_rd_ptr];

	// ------------------------------------------------------------
	// storage
	// ------------------------------------------------------------

	always_ff @(posedge i_clk) begin
		if (w_wr_fire) begin
			mem[r_wr_ptr] <= i_wr_data;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_wr_ptr <= '0;
			r_rd_ptr <= '0;
			r_count  <= '0;
		end else begin
			if (w_wr_fire) begin
				r_wr_ptr <= ptr_t'(r_wr_ptr + 1'b1);
			end
			if (w_rd_fire) begin
				r_rd_ptr <= ptr_t'(r_rd_ptr + 1'b1);
			end
			// simultaneous read and write leaves the count
			case ({w_wr_fire, w_rd_fire})
				2'b10:   r_count <= r_count + 1'b1;
				2'b01:   r_count <= r_count - 1'b1;
				default: r_count <= r_count;
			endcase
		end
	end

	a_count_max: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		r_count <= fifo_cnt_t'(FIFO_DEPTH))
		else $error("FIFO count above depth");

	// a full queue keeps its write pointer
	a_no_wr_full: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		w_full |=> $stable(r_wr_ptr))
		else $error("write accepted while FIFO full");

	// an empty queue keeps its read pointer
	a_no_rd_empty: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		w_empty |=> $stable(r_rd_ptr))
		else $error("read taken while FIFO empty");

endmodule

// ==== source/index_cal.sv ====
// one measurement in flight; i_pulse_start and i_pulse_divid must hold while busy, divid above start
`timescale 1ns/1ns

module index_cal (
	input  logic                  i_clk,
	input  logic                  i_rst_n,
	input  logic                  i_req_valid,
	output logic                  o_req_ready,
	input  dist_cfg_pkg::meas_t   i_rise_data,
	input  dist_cfg_pkg::meas_t   i_pulse_data,
	input  dist_cfg_pkg::angle_t  i_angle1,
	input  dist_cfg_pkg::angle_t  i_angle2,
	input  dist_cfg_pkg::meas_t   i_pulse_start,
	input  dist_cfg_pkg::meas_t   i_pulse_divid,
	output logic                  o_wr_valid,
	output index_rec_pkg::rec_t   o_wr_data,
	input  logic                  i_wr_ready
);

	import dist_cfg_pkg::*;
	import index_rec_pkg::*;

	// one-hot states, one per pipeline step
	typedef enum logic [7:0] {
		ST_IDLE      = 8'b0000_0001,
		ST_RANGE     = 8'b0000_0010,
		ST_RISE_IDX  = 8'b0000_0100,
		ST_PULSE_CHK = 8'b0000_1000,
		ST_PULSE_IDX = 8'b0001_0000,
		ST_PULSE_SUM = 8'b0010_0000,
		ST_REMAIN    = 8'b0100_0000,
		ST_WRITE     = 8'b1000_0000
	} state_t;

	state_t state;
	state_t state_nxt;

	// captured measurement
	meas_t  r_rise;
	meas_t  r_pulse;
	angle_t r_angle1;
	angle_t r_angle2;

	// classification
	logic r_invalid;
	logic r_coarse;
	logic w_out_of_range;

	// rise grid
	idx_t  r_rise_idx;
	meas_t r_rise_base;
	rem_t  r_rise_rem;

	// pulse grid
	idx_t  r_fine_cnt;
	idx_t  r_coarse_cnt;
	idx_t  r_pulse_idx;
	meas_t r_pulse_base;
	rem_t  r_pulse_rem;

	// write side
	flag_t w_flags;
	logic  r_wr_valid;
	rec_t  r_wr_data;

	// both range rules checked in one step
	// so every invalid record takes the same short path
	assign w_out_of_range = (r_rise >= RISE_LIMIT) || (r_pulse <= i_pulse_start);

	always_comb begin
		w_flags = '0;
		w_flags[FLAG_DONE] = 1'b1;
		w_flags[FLAG_INVALID] = r_invalid;
		w_flags[FLAG_COARSE] = r_coarse;
	end

	// ------------------------------------------------------------
	// state machine
	// ------------------------------------------------------------

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (i_req_valid) begin
					state_nxt = ST_RANGE;
				end
			end
			ST_RANGE: begin
				// invalid skips straight to the record build
				if (w_out_of_range) begin
					state_nxt = ST_REMAIN;
				end else begin
					state_nxt = ST_RISE_IDX;
				end
			end
			ST_RISE_IDX:  state_nxt = ST_PULSE_CHK;
			ST_PULSE_CHK: state_nxt = ST_PULSE_IDX;
			ST_PULSE_IDX: state_nxt = ST_PULSE_SUM;
			ST_PULSE_SUM: state_nxt = ST_REMAIN;
			ST_REMAIN:    state_nxt = ST_WRITE;
			ST_WRITE: begin
				// stall here until the FIFO takes the record
				if (r_wr_valid && i_wr_ready) begin
					state_nxt = ST_IDLE;
				end
			end
			default: state_nxt = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state <= ST_IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// valid rises on the first edge in ST_WRITE
	// drops on the accepting edge
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_wr_valid <= 1'b0;
		end else if (state == ST_WRITE) begin
			if (!r_wr_valid) begin
				r_wr_valid <= 1'b1;
			end else if (i_wr_ready) begin
				r_wr_valid <= 1'b0;
			end
		end
	end

	// ------------------------------------------------------------
	// datapath
	// ------------------------------------------------------------

	always_ff @(posedge i_clk) begin
		case (state)
			ST_IDLE: begin
				if (i_req_valid) begin
					r_rise    <= i_rise_data;
					r_pulse   <= i_pulse_data;
					r_angle1  <= i_angle1;
					r_angle2  <= i_angle2;
					r_invalid <= 1'b0;
					r_coarse  <= 1'b0;
				end
			end
			ST_RANGE: begin
				r_invalid <= w_out_of_range;
			end
			ST_RISE_IDX: begin
				// bits 23..8 of the rise time
				r_rise_idx  <= idx_t'(r_rise >> RISE_STEP_LOG2);
				// floor to the 256 grid
				r_rise_base <= (r_rise >> RISE_STEP_LOG2) << RISE_STEP_LOG2;
			end
			ST_PULSE_CHK: begin
				r_coarse <= (r_pulse >= i_pulse_divid);
			end
			ST_PULSE_IDX: begin
				if (r_coarse) begin
					// full fine span, then coarse steps past the divide point
					r_fine_cnt   <= idx_t'((i_pulse_divid - i_pulse_start) >> PULSE_FINE_LOG2);
					r_coarse_cnt <= idx_t'((r_pulse - i_pulse_divid) >> PULSE_COARSE_LOG2);
				end else begin
					r_fine_cnt   <= idx_t'((r_pulse - i_pulse_start) >> PULSE_FINE_LOG2);
					r_coarse_cnt <= '0;
				end
			end
			ST_PULSE_SUM: begin
				r_pulse_idx  <= r_fine_cnt + r_coarse_cnt;
				// grid point at or below the pulse width
				r_pulse_base <= i_pulse_start
					+ (meas_t'(r_fine_cnt) << PULSE_FINE_LOG2)
					+ (meas_t'(r_coarse_cnt) << PULSE_COARSE_LOG2);
			end
			ST_REMAIN: begin
				if (r_invalid) begin
					r_rise_idx  <= '0;
					r_rise_rem  <= '0;
					r_pulse_idx <= '0;
					r_pulse_rem <= '0;
				end else begin
					// truncated to the record width
					r_rise_rem  <= rem_t'(r_rise - r_rise_base);
					r_pulse_rem <= rem_t'(r_pulse - r_pulse_base);
				end
			end
			ST_WRITE: begin
				// loaded once, held through back-pressure
				if (!r_wr_valid) begin
					r_wr_data <= {w_flags, r_rise_idx, r_rise_rem, r_pulse_idx,
						r_pulse_rem, r_angle1, r_angle2};
				end
			end
			default: begin
			end
		endcase
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------

	assign o_req_ready = (state == ST_IDLE);
	assign o_wr_valid  = r_wr_valid;
	assign o_wr_data   = r_wr_data;

	// offered record holds until the FIFO accepts it
	a_wr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_wr_valid && !i_wr_ready |=> o_wr_valid && $stable(o_wr_data))
		else $error("write record changed before it was accepted");

	a_state_legal: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		state inside {ST_IDLE, ST_RANGE, ST_RISE_IDX, ST_PULSE_CHK,
			ST_PULSE_IDX, ST_PULSE_SUM, ST_REMAIN, ST_WRITE})
		else $error("calculator state left the legal set");

	// a new request is never taken while a record is pending
	a_one_in_flight: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_req_ready && o_wr_valid))
		else $error("request ready while a record is still offered");

endmodule

// ==== source/index_rec_pkg.sv ====
// record layout for the coefficient table stage; widths are fixed to the 88-bit table format
package index_rec_pkg;

	// ------------------------------------------------------------
	// record fields
	// ------------------------------------------------------------

	// coefficient table index
	typedef logic [15:0] idx_t;

	// remainder inside one grid step, low 10 bits only
	typedef logic [9:0] rem_t;

	// status flags in the top nibble
	typedef logic [3:0] flag_t;

	// ------------------------------------------------------------
	// flag bit positions
	// ------------------------------------------------------------

	// out of range, indices and remainders are zero
	localparam int unsigned FLAG_INVALID = 0;

	// pulse width at or above the divide point
	localparam int unsigned FLAG_COARSE = 1;

	// set on every record that leaves the calculator
	localparam int unsigned FLAG_DONE = 3;

	// ------------------------------------------------------------
	// whole record
	// ------------------------------------------------------------

	// msb first: flags, rise idx, rise rem, pulse idx, pulse rem,
	// angle 1, angle 2
	localparam int unsigned REC_W = 88;

	typedef logic [REC_W-1:0] rec_t;

endpackage

// ==== source/dist_cfg_pkg.sv ====
// measurement widths, grid steps and FIFO depth; FIFO_DEPTH must stay a power of two
package dist_cfg_pkg;

	// ------------------------------------------------------------
	// measurement values
	// ------------------------------------------------------------

	// rise time or pulse width, sub-nanosecond units
	typedef logic [31:0] meas_t;

	// scan angle as delivered by the encoder path
	typedef logic [15:0] angle_t;

	// ------------------------------------------------------------
	// range limits and grid steps
	// ------------------------------------------------------------

	// rise time at or above this is out of range
	// roughly 45 m at 200 ns / 65536 per lsb
	localparam meas_t RISE_LIMIT = 32'd98304;

	// rise grid, step 256
	localparam int unsigned RISE_STEP_LOG2 = 8;

	// pulse grid below the divide point, step 128
	localparam int unsigned PULSE_FINE_LOG2 = 7;

	// pulse grid at and above the divide point, step 512
	localparam int unsigned PULSE_COARSE_LOG2 = 9;

	// ------------------------------------------------------------
	// record queue
	// ------------------------------------------------------------

	// finished records held ahead of the fetch engine
	localparam int unsigned FIFO_DEPTH = 128;

	// fill count, one bit wider than the pointers
	// so that a full queue is distinct from an empty one
	typedef logic [7:0] fifo_cnt_t;

endpackage
